//--- design/data_ram.sv
// Word-wide data memory with byte-lane writes and a registered read address
`timescale 1ns/1ns
`default_nettype none

module data_ram
    import wb_pkg::*;
(
    input  wire              clk,
    input  wire  [XLEN-1:0]  addr_i,
    input  wire              wr_en_i,
    input  wire  [3:0]       byte_en_i,
    input  wire  [XLEN-1:0]  wr_data_i,
    input  wire              rd_en_i,
    output logic [XLEN-1:0]  rd_data_o
);

    logic [XLEN-1:0]       mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] word_addr;
    logic [RAM_ADDR_W-1:0] rd_addr_q;

    // Byte offset bits are dropped
    assign word_addr = addr_i[RAM_ADDR_W+1:2];

    // --------------------------------------------------------------------------
    // Write lanes and read address capture
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en_i[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= wr_data_i[lane*8 +: 8];
                end
            end
        end
        // Address only moves on a new read, so data stays put through the wait
        if (rd_en_i) begin
            rd_addr_q <= word_addr;
        end
    end

    assign rd_data_o = mem[rd_addr_q];

endmodule

`default_nettype wire

//--- design/flow_ctrl.sv
// Flow FSM that steers the MEM/WB register and stalls upstream during load wait states
`timescale 1ns/1ns
`default_nettype none

module flow_ctrl
    import wb_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   ex_valid_i,
    input  wire   is_load_i,
    input  wire   flush_i,
    input  wire   wait_done_i,
    output flow_t flow_o,
    output logic  stall_o,
    output logic  timer_start_o
);

    logic state_q;
    logic state_d;
    logic accept;

    // Nothing is taken while waiting on the data memory
    assign accept  = (state_q == ST_RUN) && ex_valid_i && !flush_i;
    assign stall_o = (state_q == ST_WAIT);

    // --------------------------------------------------------------------------
    // Flow code and next state
    // --------------------------------------------------------------------------
    always_comb begin
        flow_o        = FLOW_REFRESH;
        timer_start_o = 1'b0;
        state_d       = state_q;
        case (state_q)
            ST_RUN: begin
                if (accept) begin
                    flow_o = FLOW_WORK;
                    if (is_load_i) begin
                        timer_start_o = 1'b1;
                        state_d       = ST_WAIT;
                    end
                end
            end
            default: begin
                // Last wait cycle puts the register back in work so the load commits
                if (wait_done_i) begin
                    flow_o  = FLOW_WORK;
                    state_d = ST_RUN;
                end else begin
                    flow_o = FLOW_STOP;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

//--- design/load_align.sv
// Load lane selection and extension, and choice of the register writeback value
`timescale 1ns/1ns
`default_nettype none

module load_align
    import wb_pkg::*;
(
    wb_stage_if.align               wb_i,
    input  wire  [XLEN-1:0]         mem_data_i,
    input  wire                     commit_i,
    output logic                    wb_en_o,
    output logic [REG_ADDR_W-1:0]   wb_addr_o,
    output logic [XLEN-1:0]         wb_data_o,
    output logic [XLEN-1:0]         wb_pc_o,
    output logic [XLEN-1:0]         wb_inst_o
);

    load_word_u      word;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [XLEN-1:0] load_data;

    assign word     = mem_data_i;
    assign byte_sel = word.bytes[wb_i.addr_index];
    // Upper index bit picks the halfword
    assign half_sel = word.halves[wb_i.addr_index[1]];

    always_comb begin
        case (wb_i.load_kind)
            LD_B:    load_data = {{24{byte_sel[7]}}, byte_sel};
            LD_BU:   load_data = {24'b0, byte_sel};
            LD_H:    load_data = {{16{half_sel[15]}}, half_sel};
            LD_HU:   load_data = {16'b0, half_sel};
            default: load_data = word;
        endcase
    end

    assign wb_data_o = wb_i.is_load ? load_data : wb_i.alu_result;
    assign wb_en_o   = commit_i && wb_i.reg_wr_en;
    assign wb_addr_o = wb_i.rd_addr;
    assign wb_pc_o   = wb_i.pc;
    assign wb_inst_o = wb_i.inst;

endmodule

`default_nettype wire

//--- design/mem_wait_timer.sv
// Down-counter timing the data memory wait states of each accepted load
`timescale 1ns/1ns
`default_nettype none

module mem_wait_timer
    import wb_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start_i,
    output logic done_o
);

    logic [WAIT_CNT_W-1:0] cnt_q;

    // Reload on start, otherwise run down and rest at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= WAIT_CNT_W'(LOAD_WAIT);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // High during the final wait cycle
    assign done_o = (cnt_q == WAIT_CNT_W'(1));

endmodule

`default_nettype wire

//--- design/mem_wb_reg.sv
// MEM/WB pipeline register steered by work, stop and refresh, with the read-data hold
`timescale 1ns/1ns
`default_nettype none

module mem_wb_reg
    import wb_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire flow_t              flow_i,
    input  wire  [XLEN-1:0]         inst_i,
    input  wire  [XLEN-1:0]         pc_i,
    input  wire  [REG_ADDR_W-1:0]   rd_addr_i,
    input  wire                     reg_wr_en_i,
    input  wire  [XLEN-1:0]         alu_result_i,
    input  wire                     is_load_i,
    input  wire load_kind_t         load_kind_i,
    input  wire  [XLEN-1:0]         ram_data_i,
    wb_stage_if.stage               wb_o,
    output logic [XLEN-1:0]         mem_data_o,
    output logic                    commit_o
);

    flow_t                 flow_flag_q;
    logic                  reg_wr_en_q;
    logic                  is_load_q;
    logic                  commit_q;
    logic [XLEN-1:0]       inst_q;
    logic [XLEN-1:0]       pc_q;
    logic [REG_ADDR_W-1:0] rd_addr_q;
    logic [XLEN-1:0]       alu_result_q;
    load_kind_t            load_kind_q;
    logic [XLEN-1:0]       mem_data_prev_q;

    // --------------------------------------------------------------------------
    // Control fields and commit
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flow_flag_q <= FLOW_REFRESH;
            reg_wr_en_q <= 1'b0;
            is_load_q   <= 1'b0;
            commit_q    <= 1'b0;
        end else begin
            case (flow_i)
                FLOW_WORK: begin
                    flow_flag_q <= FLOW_WORK;
                    reg_wr_en_q <= reg_wr_en_i;
                    is_load_q   <= is_load_i;
                    // A load only commits on the work that ends its stop cycles
                    commit_q    <= reg_wr_en_i && (!is_load_i || flow_flag_q == FLOW_STOP);
                end
                FLOW_STOP: begin
                    flow_flag_q <= FLOW_STOP;
                    commit_q    <= 1'b0;
                end
                default: begin
                    flow_flag_q <= FLOW_REFRESH;
                    reg_wr_en_q <= 1'b0;
                    is_load_q   <= 1'b0;
                    commit_q    <= 1'b0;
                end
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Payload fields
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        mem_data_prev_q <= mem_data_o;
        if (flow_i == FLOW_WORK) begin
            inst_q       <= inst_i;
            pc_q         <= pc_i;
            rd_addr_q    <= rd_addr_i;
            alu_result_q <= alu_result_i;
            load_kind_q  <= load_kind_i;
        end else if (flow_i != FLOW_STOP) begin
            inst_q       <= '0;
            pc_q         <= '0;
            rd_addr_q    <= '0;
            alu_result_q <= '0;
            load_kind_q  <= LD_W;
        end
    end

    // Stop replays what was presented last cycle
    always_comb begin
        case (flow_flag_q)
            FLOW_WORK: mem_data_o = ram_data_i;
            FLOW_STOP: mem_data_o = mem_data_prev_q;
            default:   mem_data_o = '0;
        endcase
    end

    assign commit_o = commit_q;

    assign wb_o.inst       = inst_q;
    assign wb_o.pc         = pc_q;
    assign wb_o.rd_addr    = rd_addr_q;
    assign wb_o.reg_wr_en  = reg_wr_en_q;
    assign wb_o.alu_result = alu_result_q;
    assign wb_o.is_load    = is_load_q;
    assign wb_o.load_kind  = load_kind_q;
    assign wb_o.addr_index = alu_result_q[1:0];

endmodule

`default_nettype wire

//--- design/mem_wb_top.sv
// Top level of the memory/writeback tail, taking execute results and issuing register writes
`timescale 1ns/1ns
`default_nettype none

module mem_wb_top
    import wb_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     ex_valid_i,
    input  wire                     flush_i,
    input  wire  [XLEN-1:0]         inst_i,
    input  wire  [XLEN-1:0]         pc_i,
    input  wire  [REG_ADDR_W-1:0]   rd_addr_i,
    input  wire                     reg_wr_en_i,
    input  wire  [XLEN-1:0]         alu_result_i,
    input  wire                     mem_rd_i,
    input  wire                     mem_wr_i,
    input  wire  [XLEN-1:0]         store_data_i,
    input  wire load_kind_t         load_kind_i,
    output logic                    stall_o,
    output logic                    wb_en_o,
    output logic [REG_ADDR_W-1:0]   wb_addr_o,
    output logic [XLEN-1:0]         wb_data_o,
    output logic [XLEN-1:0]         wb_pc_o,
    output logic [XLEN-1:0]         wb_inst_o
);

    flow_t           flow;
    logic            timer_start;
    logic            wait_done;
    logic            accept;
    logic            ram_wr_en;
    logic            ram_rd_en;
    logic [3:0]      ram_byte_en;
    logic [XLEN-1:0] ram_rd_data;
    logic [XLEN-1:0] mem_data;
    logic            commit;

    wb_stage_if wb_if ();

    // Work outside the wait is a fresh acceptance
    assign accept      = (flow == FLOW_WORK) && !stall_o;
    assign ram_wr_en   = accept && mem_wr_i;
    assign ram_rd_en   = accept && mem_rd_i;
    assign ram_byte_en = store_byte_en(load_kind_i, alu_result_i[1:0]);

    // --------------------------------------------------------------------------
    // Flow control and wait timing
    // --------------------------------------------------------------------------
    flow_ctrl u_flow_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid_i    (ex_valid_i),
        .is_load_i     (mem_rd_i),
        .flush_i       (flush_i),
        .wait_done_i   (wait_done),
        .flow_o        (flow),
        .stall_o       (stall_o),
        .timer_start_o (timer_start)
    );

    mem_wait_timer u_mem_wait_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (timer_start),
        .done_o  (wait_done)
    );

    // --------------------------------------------------------------------------
    // Memory, pipeline register and writeback
    // --------------------------------------------------------------------------
    data_ram u_data_ram (
        .clk       (clk),
        .addr_i    (alu_result_i),
        .wr_en_i   (ram_wr_en),
        .byte_en_i (ram_byte_en),
        .wr_data_i (store_data_i),
        .rd_en_i   (ram_rd_en),
        .rd_data_o (ram_rd_data)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .flow_i       (flow),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rd_addr_i    (rd_addr_i),
        .reg_wr_en_i  (reg_wr_en_i),
        .alu_result_i (alu_result_i),
        .is_load_i    (mem_rd_i),
        .load_kind_i  (load_kind_i),
        .ram_data_i   (ram_rd_data),
        .wb_o         (wb_if.stage),
        .mem_data_o   (mem_data),
        .commit_o     (commit)
    );

    load_align u_load_align (
        .wb_i       (wb_if.align),
        .mem_data_i (mem_data),
        .commit_i   (commit),
        .wb_en_o    (wb_en_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .wb_pc_o    (wb_pc_o),
        .wb_inst_o  (wb_inst_o)
    );

endmodule

`default_nettype wire

//--- design/wb_pkg.sv
// Shared widths, flow codes, load kinds and wait constants, imported by every block of the MEM/WB tail
`default_nettype none

package wb_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Data memory size and load wait states
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);
    localparam int LOAD_WAIT  = 2;
    localparam int WAIT_CNT_W = 2;

    // State encoding of the flow FSM
    localparam logic ST_RUN  = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    // Pipeline register steering
    typedef enum logic [1:0] {
        FLOW_WORK    = 2'd0,
        FLOW_STOP    = 2'd1,
        FLOW_REFRESH = 2'd2
    } flow_t;

    // Access size, also used as the store size
    typedef enum logic [2:0] {
        LD_W  = 3'd0,
        LD_H  = 3'd1,
        LD_HU = 3'd2,
        LD_B  = 3'd3,
        LD_BU = 3'd4
    } load_kind_t;

    // One loaded word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

    // Byte lanes touched by a store of the given size at the given offset
    function automatic logic [3:0] store_byte_en(input load_kind_t kind,
                                                 input logic [1:0] index);
        logic [3:0] mask;
        case (kind)
            LD_H, LD_HU: mask = index[1] ? 4'b1100 : 4'b0011;
            LD_B, LD_BU: mask = 4'b0001 << index;
            default:     mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- design/wb_stage_if.sv
// Held MEM/WB instruction fields, driven by the pipeline register and read by the load aligner
`timescale 1ns/1ns
`default_nettype none

interface wb_stage_if
    import wb_pkg::*;
();

    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  reg_wr_en;
    logic [XLEN-1:0]       alu_result;
    logic                  is_load;
    load_kind_t            load_kind;
    // Low address bits for lane selection
    logic [1:0]            addr_index;

    modport stage (
        output inst, pc, rd_addr, reg_wr_en, alu_result, is_load, load_kind, addr_index
    );

    modport align (
        input inst, pc, rd_addr, reg_wr_en, alu_result, is_load, load_kind, addr_index
    );

endinterface

`default_nettype wire

//--- dv/mem_wb_properties.sv
// Concurrent assertions on stall, writeback strobe and flow code, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module mem_wb_properties
    import wb_pkg::*;
(
    input wire        clk,
    input wire        rst_n,
    input wire        stall_i,
    input wire        wb_en_i,
    input wire flow_t flow_i
);

    a_no_wb_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> !wb_en_i) else $error("wb_en_o high while stall_o is high");

    a_stall_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(stall_i) |-> stall_i[*LOAD_WAIT] ##1 !stall_i)
        else $error("stall_o length differs from LOAD_WAIT");

    a_flow_legal: assert property (@(posedge clk) disable iff (!rst_n)
        flow_i inside {FLOW_WORK, FLOW_STOP, FLOW_REFRESH}) else $error("Illegal flow code");

    // First cycle out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !stall_i && !wb_en_i) else $error("Strobes high after reset");

endmodule

bind mem_wb_top mem_wb_properties u_props (
    .clk(clk), .rst_n(rst_n), .stall_i(stall_o), .wb_en_i(wb_en_o), .flow_i(flow)
);

`default_nettype wire

//--- dv/mem_wb_tests.txt
# op flush rd reg_wr_en addr_or_result(hex) store_data(hex, lane replicated) kind expected(hex)
# kind: 0 W, 1 H, 2 HU, 3 B, 4 BU
alu   0 1  1 00000011 00000000 0 00000011
alu   0 2  0 00000022 00000000 0 00000000
store 0 0  0 00000040 8899aabb 0 00000000
load  0 3  1 00000040 00000000 0 8899aabb
store 0 0  0 00000044 11223344 0 00000000
store 0 0  0 00000044 c5c5c5c5 3 00000000
load  0 4  1 00000044 00000000 0 112233c5
store 0 0  0 00000046 7e7e7e7e 3 00000000
load  0 5  1 00000044 00000000 0 117e33c5
load  0 10 1 00000044 00000000 3 ffffffc5
load  0 11 1 00000044 00000000 4 000000c5
load  0 12 1 00000046 00000000 3 0000007e
load  0 13 1 00000047 00000000 3 00000011
load  0 14 1 00000045 00000000 4 00000033
load  0 15 1 00000040 00000000 1 ffffaabb
load  0 16 1 00000042 00000000 2 00008899
load  0 17 1 00000042 00000000 1 ffff8899
load  0 18 1 00000044 00000000 2 000033c5
store 1 0  0 00000040 deadbeef 0 00000000
alu   1 6  1 00000066 00000000 0 00000066
load  0 19 1 00000040 00000000 0 8899aabb
store 0 0  0 00000042 12341234 1 00000000
load  0 20 1 00000040 00000000 0 1234aabb
alu   0 7  1 0000abcd 00000000 0 0000abcd
load  0 8  0 00000040 00000000 0 00000000
alu   0 9  1 ffffffff 00000000 0 ffffffff

//--- dv/tb_mem_wb.sv
// Testbench top for the MEM/WB tail; replays the tests file into the DUT and reports the result
`timescale 1ns/1ns
`default_nettype none

module tb_mem_wb
    import wb_pkg::*;
();

    localparam int MAX_LINES = 64;

    logic clk, rst_n, ex_valid, flush, reg_wr_en, mem_rd, mem_wr;
    logic [XLEN-1:0] inst, pc, alu_result, store_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    load_kind_t load_kind;
    logic stall, wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0] wb_data, wb_pc, wb_inst;

    // One entry per line of the tests file
    logic [8*8-1:0]  op_a    [MAX_LINES];
    int              flush_a [MAX_LINES];
    int              rd_a    [MAX_LINES];
    int              wen_a   [MAX_LINES];
    logic [XLEN-1:0] addr_a  [MAX_LINES];
    logic [XLEN-1:0] sdata_a [MAX_LINES];
    int              kind_a  [MAX_LINES];
    logic [XLEN-1:0] exp_a   [MAX_LINES];

    int n_lines, fd, code, cyc, limit, due, setup_err;
    string line;

    mem_wb_top u_dut (
        .clk(clk), .rst_n(rst_n), .ex_valid_i(ex_valid), .flush_i(flush),
        .inst_i(inst), .pc_i(pc), .rd_addr_i(rd_addr), .reg_wr_en_i(reg_wr_en),
        .alu_result_i(alu_result), .mem_rd_i(mem_rd), .mem_wr_i(mem_wr),
        .store_data_i(store_data), .load_kind_i(load_kind), .stall_o(stall),
        .wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
        .wb_pc_o(wb_pc), .wb_inst_o(wb_inst)
    );

    wb_checker u_chk (
        .clk(clk), .rst_n(rst_n), .cyc_i(cyc), .stall_i(stall), .wb_en_i(wb_en),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_pc_i(wb_pc), .wb_inst_i(wb_inst)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------------------------------
    // Cycle count and timeout
    // --------------------------------------------------------------------------
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            $display("Timeout at cycle %0d with %0d writebacks outstanding",
                     cyc, u_chk.exp_pc.size());
            $display("Errors: %0d value mismatches, %0d other", u_chk.fail_cnt,
                     u_chk.other_cnt + setup_err + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        {ex_valid, flush, reg_wr_en, mem_rd, mem_wr} = '0;
        {inst, pc, alu_result, store_data} = '0;
        rd_addr = '0;
        load_kind = LD_W;
        cyc = 0;
        limit = 1000000;
        n_lines = 0;
        setup_err = 0;

        fd = $fopen("dv/mem_wb_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file dv/mem_wb_tests.txt");
            setup_err++;
        end else begin
            // Lines starting with # describe the columns
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%s %d %d %d %h %h %d %h", op_a[n_lines],
                                   flush_a[n_lines], rd_a[n_lines], wen_a[n_lines],
                                   addr_a[n_lines], sdata_a[n_lines], kind_a[n_lines],
                                   exp_a[n_lines]);
                    if (code == 8) begin
                        n_lines++;
                    end else begin
                        $display("Malformed line in the tests file: %s", line);
                        setup_err++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("No test lines were read from the tests file");
                setup_err++;
            end
        end
        limit = n_lines * (LOAD_WAIT + 3) + 50;

        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        // ----------------------------------------------------------------------
        // Driver presenting one line per accepted slot
        // ----------------------------------------------------------------------
        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            #1;
            while (stall) begin
                @(posedge clk);
                #1;
            end
            ex_valid   = 1'b1;
            flush      = (flush_a[i] != 0);
            rd_addr    = rd_a[i][REG_ADDR_W-1:0];
            reg_wr_en  = (wen_a[i] != 0);
            alu_result = addr_a[i];
            store_data = sdata_a[i];
            load_kind  = load_kind_t'(kind_a[i]);
            mem_rd     = (op_a[i] == "load");
            mem_wr     = (op_a[i] == "store");
            pc         = 32'h1000 + 4 * i;
            inst       = 32'h0000_0013 + (i << 7);
            // Accepted at the next edge and written back one or LOAD_WAIT+1 cycles later
            due = mem_rd ? cyc + 1 + LOAD_WAIT : cyc + 1;
            if (!flush && reg_wr_en) begin
                u_chk.push_expect(rd_addr, exp_a[i], pc, inst, due);
            end
        end
        @(posedge clk);
        #1;
        while (stall) begin
            @(posedge clk);
            #1;
        end
        ex_valid = 1'b0;
        while (u_chk.exp_pc.size() != 0) @(posedge clk);
        repeat (5) @(posedge clk);

        $display("Errors: %0d value mismatches, %0d other", u_chk.fail_cnt,
                 u_chk.other_cnt + setup_err);
        if (u_chk.fail_cnt == 0 && u_chk.other_cnt == 0 && setup_err == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/wb_checker.sv
// Writeback checker; matches each register write of the DUT against the queued expectations
`timescale 1ns/1ns
`default_nettype none

module wb_checker
    import wb_pkg::*;
(
    input wire                  clk,
    input wire                  rst_n,
    input wire [31:0]           cyc_i,
    input wire                  stall_i,
    input wire                  wb_en_i,
    input wire [REG_ADDR_W-1:0] wb_addr_i,
    input wire [XLEN-1:0]       wb_data_i,
    input wire [XLEN-1:0]       wb_pc_i,
    input wire [XLEN-1:0]       wb_inst_i
);

    logic [REG_ADDR_W-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    logic [XLEN-1:0] exp_pc [$];
    logic [XLEN-1:0] exp_inst [$];
    int exp_cyc [$];
    int fail_cnt = 0;
    int other_cnt = 0;
    int stall_len = 0;
    logic rst_q = 1'b0;

    task automatic push_expect(input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data,
                               input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst,
                               input int due);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_pc.push_back(pc);
        exp_inst.push_back(inst);
        exp_cyc.push_back(due);
    endtask

    task automatic compare_field(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_cnt++;
        end
    endtask

    // Outputs move at rising edges, so look at them on the falling edge
    always @(negedge clk) begin
        rst_q <= rst_n;
        if (rst_n) begin
            if (!rst_q && (wb_en_i || stall_i)) begin
                $display("Strobes not low in the first cycle after reset at %0t", $time);
                other_cnt++;
            end
            if (stall_i && wb_en_i) begin
                $display("Writeback raised during a stall at %0t", $time);
                other_cnt++;
            end
            if (stall_i) begin
                stall_len++;
            end else if (stall_len != 0) begin
                if (stall_len != LOAD_WAIT) begin
                    $display("Stall lasted %0d cycles instead of %0d", stall_len, LOAD_WAIT);
                    other_cnt++;
                end
                stall_len = 0;
            end
            if (exp_cyc.size() != 0 && !wb_en_i && exp_cyc[0] < cyc_i) begin
                $display("Writeback due at cycle %0d never came", exp_cyc[0]);
                other_cnt++;
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_pc.pop_front());
                void'(exp_inst.pop_front());
                void'(exp_cyc.pop_front());
            end
            if (wb_en_i) begin
                if (exp_cyc.size() == 0) begin
                    $display("Unexpected writeback at %0t to register %0d", $time, wb_addr_i);
                    other_cnt++;
                end else begin
                    if (exp_cyc[0] != cyc_i) begin
                        $display("Writeback at cycle %0d, expected at cycle %0d", cyc_i,
                                 exp_cyc[0]);
                        other_cnt++;
                    end
                    compare_field("wb_addr_o", XLEN'(wb_addr_i), XLEN'(exp_addr.pop_front()));
                    compare_field("wb_data_o", wb_data_i, exp_data.pop_front());
                    compare_field("wb_pc_o", wb_pc_i, exp_pc.pop_front());
                    compare_field("wb_inst_o", wb_inst_i, exp_inst.pop_front());
                    void'(exp_cyc.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the MEM/WB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_wb -o sim_mem_wb
output=$(./obj_dir/sim_mem_wb)
echo "$output"

if echo "$output" | grep -q "Testbench passed"; then
    exit 0
fi
exit 1

//--- vlog.f
design/wb_pkg.sv
design/wb_stage_if.sv
design/flow_ctrl.sv
design/mem_wait_timer.sv
design/data_ram.sv
design/mem_wb_reg.sv
design/load_align.sv
design/mem_wb_top.sv
dv/mem_wb_properties.sv
dv/wb_checker.sv
dv/tb_mem_wb.sv
